//--- Makefile
VERILATOR ?= verilator
TOP       ?= packet_parse_tb
FILELIST  ?= packet_parse_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- packet_parse_top.f
+incdir+rtl
rtl/packet_parse_pkg.sv
rtl/field_shifter.sv
rtl/ebv_pointer_decoder.sv
rtl/handle_matcher.sv
rtl/packet_sequencer.sv
rtl/packet_parse_top.sv
verification/packet_parse_properties.sv
verification/packet_parse_tb.sv

//--- rtl/ebv_pointer_decoder.sv
// EBV-8 word pointer decode, skips extended blocks and keeps the last block's value bits
`timescale 1ns/1ps
`include "packet_parse_settings.svh"

module ebv_pointer_decoder (
  input  logic                        bitinclk,
  input  logic                        reset,
  input  logic                        enable,
  input  logic                        bitin,
  output packet_parse_pkg::word_ptr_t pointer,
  output logic                        done
);

  import packet_parse_pkg::*;

  localparam int BW = `PP_EBV_BLOCK;
  localparam int CW = $clog2(BW);
  localparam logic [CW-1:0] LAST = CW'(BW - 1);

  logic [CW-1:0] bit_cnt;
  // flag of the current block was 0
  logic          last_block;
  logic [BW-2:0] value_q;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      bit_cnt    <= '0;
      last_block <= 1'b0;
      value_q    <= '0;
      done       <= 1'b0;
    end else if (enable && !done) begin
      // first bit of a block is the extension flag
      if (bit_cnt == '0) begin
        last_block <= !bitin;
      end else begin
        // a full block of value bits overwrites the earlier block
        value_q <= {value_q[BW-3:0], bitin};
      end

      if (bit_cnt == LAST) begin
        bit_cnt <= '0;
        if (last_block) begin
          done <= 1'b1;
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign pointer = word_ptr_t'({1'b0, value_q});

endmodule

//--- rtl/field_shifter.sv
// serial MSB-first field capture with its own bit counter, any payload type
`timescale 1ns/1ps

module field_shifter #(
  parameter type field_t = logic [7:0]
) (
  input  logic   bitinclk,
  input  logic   reset,
  input  logic   enable,
  input  logic   bitin,
  output field_t value,
  output logic   done
);

  localparam int W = $bits(field_t);
  localparam int CW = (W > 1) ? $clog2(W) : 1;
  localparam logic [CW-1:0] LAST = CW'(W - 1);

  logic [W-1:0]  shift_q;
  logic [CW-1:0] bit_cnt;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      shift_q <= '0;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else if (enable && !done) begin
      shift_q <= {shift_q[W-2:0], bitin};
      // done rises on the edge that takes the last bit
      if (bit_cnt == LAST) begin
        done <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign value = field_t'(shift_q);

endmodule

//--- rtl/handle_matcher.sv
// bitwise compare of the incoming stream against the current handle, MSB first
`timescale 1ns/1ps
`include "packet_parse_settings.svh"

module handle_matcher (
  input  logic                         bitinclk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic                         bitin,
  input  logic                         immediate,
  input  packet_parse_pkg::data_word_t current_handle,
  output logic                         match
);

  localparam int CW = $clog2(`PP_HANDLE_WIDTH);
  localparam logic [CW-1:0] LAST = CW'(`PP_HANDLE_WIDTH - 1);

  logic [CW-1:0] bit_cnt;
  logic          failed;
  logic          match_q;
  logic          bit_ok;
  logic          last_ok;

  // handle index runs from the MSB down
  assign bit_ok = (bitin == current_handle[LAST - bit_cnt]);

  // final bit matching right now, before its edge
  assign last_ok = enable && !failed && (bit_cnt == LAST) && bit_ok;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      bit_cnt <= '0;
      failed  <= 1'b0;
      match_q <= 1'b0;
    end else if (enable && !failed && !match_q) begin
      if (!bit_ok) begin
        // one wrong bit ends the compare for this packet
        failed <= 1'b1;
      end else if (bit_cnt == LAST) begin
        match_q <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // ACK has no trailing bits, so the controller sees the last compare live
  assign match = match_q | (immediate & last_ok);

endmodule

//--- rtl/packet_parse_pkg.sv
// field types and the parsed access request struct of the packet parser
`include "packet_parse_settings.svh"

package packet_parse_pkg;

  // one-hot command code, held for the whole packet
  typedef logic [`PP_CMD_WIDTH-1:0] cmd_code_t;

  typedef logic [`PP_BANK_WIDTH-1:0] bank_t;

  // top bit stays 0, only 7 value bits come from the last EBV block
  typedef logic [`PP_EBV_BLOCK-1:0] word_ptr_t;

  typedef logic [`PP_WORD_COUNT_WIDTH-1:0] word_count_t;

  // data word, also used for the handle and RN16
  typedef logic [`PP_HANDLE_WIDTH-1:0] data_word_t;

  // everything a read or write hands to the memory side
  typedef struct packed {
    bank_t       bank;
    word_ptr_t   pointer;
    word_count_t words;
    data_word_t  write_data;
  } access_req_t;

endpackage

//--- rtl/packet_parse_settings.svh
// field widths, EBV block size and one-hot command bit positions for the packet parser
`ifndef PACKET_PARSE_SETTINGS_SVH
`define PACKET_PARSE_SETTINGS_SVH

// one-hot command code from the controller
`define PP_CMD_WIDTH 13

// handle and RN16 share this width
`define PP_HANDLE_WIDTH 16

// EBV-8: one extension flag plus 7 value bits per block
`define PP_EBV_BLOCK 8

// fixed field widths of read and write
`define PP_BANK_WIDTH 2
`define PP_WORD_COUNT_WIDTH 8

// bit positions of the kept commands
`define PP_CMD_ACK 1
`define PP_CMD_REQRN 6
`define PP_CMD_READ 7
`define PP_CMD_WRITE 8

`endif

//--- rtl/packet_parse_top.sv
// packet parser top level, field units and sequencer wired into the access request
`timescale 1ns/1ps

module packet_parse_top (
  input  logic                          bitinclk,
  input  logic                          reset,
  input  logic                          bitin,
  input  packet_parse_pkg::cmd_code_t   cmd,
  input  packet_parse_pkg::data_word_t  current_handle,
  input  packet_parse_pkg::data_word_t  current_rn,
  output logic                          handle_match,
  output packet_parse_pkg::access_req_t access,
  output logic                          write_data_ready
);

  import packet_parse_pkg::*;

  logic        bank_en;
  logic        ptr_en;
  logic        words_en;
  logic        data_en;
  logic        handle_en;
  logic        immediate;
  logic        bank_done;
  logic        ptr_done;
  logic        words_done;
  bank_t       bank_val;
  word_ptr_t   ptr_val;
  word_count_t words_val;
  data_word_t  raw_data;
  data_word_t  write_data;

  packet_sequencer u_sequencer (
    .bitinclk   (bitinclk),
    .reset      (reset),
    .cmd        (cmd),
    .current_rn (current_rn),
    .bank_done  (bank_done),
    .ptr_done   (ptr_done),
    .words_done (words_done),
    .data_done  (write_data_ready),
    .raw_data   (raw_data),
    .bank_en    (bank_en),
    .ptr_en     (ptr_en),
    .words_en   (words_en),
    .data_en    (data_en),
    .handle_en  (handle_en),
    .immediate  (immediate),
    .write_data (write_data)
  );

  field_shifter #(.field_t(bank_t)) u_bank (
    .bitinclk (bitinclk),
    .reset    (reset),
    .enable   (bank_en),
    .bitin    (bitin),
    .value    (bank_val),
    .done     (bank_done)
  );

  ebv_pointer_decoder u_ptr (
    .bitinclk (bitinclk),
    .reset    (reset),
    .enable   (ptr_en),
    .bitin    (bitin),
    .pointer  (ptr_val),
    .done     (ptr_done)
  );

  field_shifter #(.field_t(word_count_t)) u_words (
    .bitinclk (bitinclk),
    .reset    (reset),
    .enable   (words_en),
    .bitin    (bitin),
    .value    (words_val),
    .done     (words_done)
  );

  // data done doubles as the write-data-ready flag
  field_shifter #(.field_t(data_word_t)) u_data (
    .bitinclk (bitinclk),
    .reset    (reset),
    .enable   (data_en),
    .bitin    (bitin),
    .value    (raw_data),
    .done     (write_data_ready)
  );

  handle_matcher u_handle (
    .bitinclk       (bitinclk),
    .reset          (reset),
    .enable         (handle_en),
    .bitin          (bitin),
    .immediate      (immediate),
    .current_handle (current_handle),
    .match          (handle_match)
  );

  assign access = '{bank: bank_val, pointer: ptr_val, words: words_val, write_data: write_data};

endmodule

//--- rtl/packet_sequencer.sv
// field phase control per command and cover-code decode of the write data
`timescale 1ns/1ps
`include "packet_parse_settings.svh"

module packet_sequencer (
  input  logic                         bitinclk,
  input  logic                         reset,
  input  packet_parse_pkg::cmd_code_t  cmd,
  input  packet_parse_pkg::data_word_t current_rn,
  input  logic                         bank_done,
  input  logic                         ptr_done,
  input  logic                         words_done,
  input  logic                         data_done,
  input  packet_parse_pkg::data_word_t raw_data,
  output logic                         bank_en,
  output logic                         ptr_en,
  output logic                         words_en,
  output logic                         data_en,
  output logic                         handle_en,
  output logic                         immediate,
  output packet_parse_pkg::data_word_t write_data
);

  import packet_parse_pkg::*;

  // body is the word count for read and the data word for write
  typedef enum logic [1:0] {
    PH_BANK,
    PH_PTR,
    PH_BODY,
    PH_HANDLE
  } phase_t;

  phase_t     phase;
  logic       is_read;
  logic       is_write;
  logic       is_rw;
  logic       is_hs;
  logic       body_done;
  logic       in_ptr;
  logic       in_body;
  data_word_t decoded;

  assign is_read  = cmd[`PP_CMD_READ];
  assign is_write = cmd[`PP_CMD_WRITE];
  assign is_rw    = is_read | is_write;
  // handle-only commands
  assign is_hs    = cmd[`PP_CMD_ACK] | cmd[`PP_CMD_REQRN];

  assign body_done = is_read ? words_done : data_done;

  // phase moves on the edge after done, so the next unit is
  // also enabled while the phase still points at the finished field
  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      phase <= PH_BANK;
    end else if (is_rw) begin
      case (phase)
        PH_BANK: begin
          if (bank_done) begin
            phase <= PH_PTR;
          end
        end
        PH_PTR: begin
          if (ptr_done) begin
            phase <= PH_BODY;
          end
        end
        PH_BODY: begin
          if (body_done) begin
            phase <= PH_HANDLE;
          end
        end
        default: begin
          phase <= PH_HANDLE;
        end
      endcase
    end
  end

  assign in_ptr  = is_rw && ((phase == PH_PTR) || ((phase == PH_BANK) && bank_done));
  assign in_body = is_rw && ((phase == PH_BODY) || ((phase == PH_PTR) && ptr_done));

  assign bank_en   = is_rw && (phase == PH_BANK);
  assign ptr_en    = in_ptr;
  assign words_en  = in_body & is_read;
  assign data_en   = in_body & is_write;
  assign handle_en = is_hs ||
                     (is_rw && ((phase == PH_HANDLE) || ((phase == PH_BODY) && body_done)));

  assign immediate = cmd[`PP_CMD_ACK];

  // write data arrives cover-coded with RN16
  assign decoded = raw_data ^ current_rn;

  // the data shifter holds the word, decode shows once the field is complete
  assign write_data = data_done ? decoded : '0;

endmodule

//--- verification/packet_parse_properties.sv
// concurrent assertions on field stability, write ordering and handle match hold
`timescale 1ns/1ps

module packet_parse_properties (
  input logic                          bitinclk,
  input logic                          reset,
  input logic                          bank_done,
  input logic                          ptr_done,
  input logic                          words_done,
  input logic                          write_data_ready,
  input logic                          handle_match,
  input packet_parse_pkg::access_req_t access
);

  // number of failed assertion attempts
  int failures = 0;

  // a captured field holds once its unit is done
  a_bank_stable: assert property (@(posedge bitinclk) disable iff (reset)
    $past(bank_done) |-> $stable(access.bank))
    else begin
      $error("access.bank changed after the bank field completed");
      failures++;
    end

  a_words_stable: assert property (@(posedge bitinclk) disable iff (reset)
    $past(words_done) |-> $stable(access.words))
    else begin
      $error("access.words changed after the word count completed");
      failures++;
    end

  a_ready_after_ptr: assert property (@(posedge bitinclk) disable iff (reset)
    write_data_ready |-> ptr_done)
    else begin
      $error("write_data_ready high before the EBV pointer completed");
      failures++;
    end

  // only reset clears a match
  a_match_held: assert property (@(posedge bitinclk)
    $fell(handle_match) |-> reset)
    else begin
      $error("handle_match fell without reset");
      failures++;
    end

endmodule

bind packet_parse_top packet_parse_properties u_props (
  .bitinclk         (bitinclk),
  .reset            (reset),
  .bank_done        (bank_done),
  .ptr_done         (ptr_done),
  .words_done       (words_done),
  .write_data_ready (write_data_ready),
  .handle_match     (handle_match),
  .access           (access)
);

//--- verification/packet_parse_stimulus.txt
# cmd bank ptr(hex) ebv_blocks(dec) words(hex) data(hex) rn(hex) handle(hex) handle_sent(hex) match
# ptr is the last EBV block's 7 value bits, data is plain and goes out as data ^ rn
reqrn 0 00 1 00 0000 3b17 a5c3 a5c3 1
reqrn 0 00 1 00 0000 3b17 a5c3 a5c7 0
ack 0 00 1 00 0000 3b17 5e21 5e21 1
ack 0 00 1 00 0000 3b17 5e21 5e20 0
read 2 35 1 04 0000 3b17 a5c3 a5c3 1
read 1 7f 3 10 0000 3b17 c0de c0de 1
read 3 12 2 01 0000 9a0f 1234 1235 0
write 1 2a 1 00 beef 3b17 a5c3 a5c3 1
write 3 05 3 00 1357 c3a5 7e81 7e81 1
query 2 11 1 08 ffff 3b17 a5c3 a5c3 0

//--- verification/packet_parse_tb.sv
// packet parser testbench with vector reading, packet serializing, output checks and a timeout
`timescale 1ns/1ps
`include "packet_parse_settings.svh"

module packet_parse_tb;

  import packet_parse_pkg::*;

  // unkept commands such as Query take this code bit
  localparam int QUERY_BIT = 0;

  typedef struct packed {
    logic [63:0] name;
    logic [1:0]  bank;
    logic [7:0]  ptr;
    logic [7:0]  blocks;
    logic [7:0]  words;
    logic [15:0] data;
    logic [15:0] rn;
    logic [15:0] handle;
    logic [15:0] sent;
    logic        match;
  } vector_t;

  logic        bitinclk;
  logic        reset;
  logic        bitin;
  cmd_code_t   cmd;
  data_word_t  current_handle;
  data_word_t  current_rn;
  logic        handle_match;
  access_req_t access;
  logic        write_data_ready;

  vector_t vectors[$];
  logic    bits_q[$];
  integer  seed = 32'hd205;
  int      error_count = 0;
  int      check_count = 0;
  int      cycle_count = 0;
  int      cycle_limit = 1000;

  packet_parse_top u_dut (
    .bitinclk         (bitinclk),
    .reset            (reset),
    .bitin            (bitin),
    .cmd              (cmd),
    .current_handle   (current_handle),
    .current_rn       (current_rn),
    .handle_match     (handle_match),
    .access           (access),
    .write_data_ready (write_data_ready)
  );

  initial begin
    bitinclk = 1'b0;
    forever #5 bitinclk = ~bitinclk;
  end

  task automatic check_field(input string sig, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL t=%0t %s got %0h expected %0h", $time, sig, actual, expected);
    end
  endtask

  task automatic load_vectors();
    logic [63:0] name;
    logic [1:0]  bank;
    logic [7:0]  ptr;
    logic [7:0]  blocks;
    logic [7:0]  words;
    logic [15:0] data;
    logic [15:0] rn;
    logic [15:0] handle;
    logic [15:0] sent;
    logic        match;
    string       line;
    int          fd;
    int          n;
    fd = $fopen("verification/packet_parse_stimulus.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open the stimulus file verification/packet_parse_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // blank lines and column notes are skipped
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %d %h %h %h %h %h %d", name, bank, ptr, blocks,
                      words, data, rn, handle, sent, match);
          if (n == 10) begin
            vectors.push_back('{name, bank, ptr, blocks, words, data, rn, handle, sent, match});
          end else begin
            error_count++;
            $display("stimulus line could not be parsed: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic cmd_code_t code_for(input logic [63:0] name);
    cmd_code_t code;
    code = '0;
    if (name == 64'("ack")) begin
      code[`PP_CMD_ACK] = 1'b1;
    end else if (name == 64'("reqrn")) begin
      code[`PP_CMD_REQRN] = 1'b1;
    end else if (name == 64'("read")) begin
      code[`PP_CMD_READ] = 1'b1;
    end else if (name == 64'("write")) begin
      code[`PP_CMD_WRITE] = 1'b1;
    end else begin
      code[QUERY_BIT] = 1'b1;
    end
    return code;
  endfunction

  task automatic push_bits(input logic [15:0] value, input int width);
    for (int b = width - 1; b >= 0; b--) begin
      bits_q.push_back(value[b]);
    end
  endtask

  task automatic build_stream(input vector_t v, input cmd_code_t code);
    logic [31:0] rnd;
    int          n_blocks;
    n_blocks = int'(v.blocks);
    bits_q.delete();
    if (code[`PP_CMD_READ] || code[`PP_CMD_WRITE]) begin
      push_bits({14'b0, v.bank}, 2);
      // leading EBV blocks carry the extension flag and throwaway value bits
      for (int k = 0; k < n_blocks - 1; k++) begin
        bits_q.push_back(1'b1);
        rnd = $random(seed);
        push_bits({9'b0, rnd[6:0]}, 7);
      end
      bits_q.push_back(1'b0);
      push_bits({9'b0, v.ptr[6:0]}, 7);
      if (code[`PP_CMD_READ]) begin
        push_bits({8'b0, v.words}, 8);
      end else begin
        // cover-coded on the air
        push_bits(v.data ^ v.rn, 16);
      end
      push_bits(v.sent, 16);
    end else if (code[`PP_CMD_ACK] || code[`PP_CMD_REQRN]) begin
      push_bits(v.sent, 16);
    end else begin
      for (int k = 0; k < 24; k++) begin
        rnd = $random(seed);
        bits_q.push_back(rnd[0]);
      end
    end
  endtask

  task automatic check_outputs(input vector_t v, input cmd_code_t code);
    logic is_read;
    logic is_write;
    logic is_rw;
    is_read  = code[`PP_CMD_READ];
    is_write = code[`PP_CMD_WRITE];
    is_rw    = is_read | is_write;
    check_field("handle_match", 32'(handle_match), 32'(v.match));
    check_field("access.bank", 32'(access.bank), is_rw ? 32'(v.bank) : 32'd0);
    check_field("access.pointer", 32'(access.pointer),
                is_rw ? 32'({1'b0, v.ptr[6:0]}) : 32'd0);
    check_field("access.words", 32'(access.words), is_read ? 32'(v.words) : 32'd0);
    check_field("access.write_data", 32'(access.write_data), is_write ? 32'(v.data) : 32'd0);
    check_field("write_data_ready", 32'(write_data_ready), is_write ? 32'd1 : 32'd0);
  endtask

  task automatic run_packet(input vector_t v);
    cmd_code_t code;
    logic      is_ack;
    logic      is_hs;
    logic      is_write;
    int        ready_at;
    code     = code_for(v.name);
    is_ack   = code[`PP_CMD_ACK];
    is_hs    = code[`PP_CMD_ACK] | code[`PP_CMD_REQRN];
    is_write = code[`PP_CMD_WRITE];
    // bits taken when the data field completes
    ready_at = 2 + 8 * int'(v.blocks) + 16;
    build_stream(v, code);
    @(posedge bitinclk);
    reset          <= 1'b1;
    bitin          <= 1'b0;
    cmd            <= code;
    current_handle <= v.handle;
    current_rn     <= v.rn;
    @(posedge bitinclk);
    for (int i = 0; i < bits_q.size(); i++) begin
      @(posedge bitinclk);
      reset <= 1'b0;
      bitin <= bits_q[i];
      @(negedge bitinclk);
      // i bits have been sampled at this point
      if (is_write && i == ready_at - 1) begin
        check_field("write_data_ready", 32'(write_data_ready), 32'd0);
      end
      if (is_write && i == ready_at) begin
        check_field("write_data_ready", 32'(write_data_ready), 32'd1);
        check_field("access.write_data", 32'(access.write_data), 32'(v.data));
      end
      // last handle bit still presented and only ACK shows the live compare
      if (is_hs && i == bits_q.size() - 1) begin
        check_field("handle_match", 32'(handle_match), is_ack ? 32'(v.match) : 32'd0);
      end
    end
    @(posedge bitinclk);
    @(negedge bitinclk);
    check_outputs(v, code);
  endtask

  initial begin
    reset          = 1'b1;
    bitin          = 1'b0;
    cmd            = '0;
    current_handle = '0;
    current_rn     = '0;
    load_vectors();
    cycle_limit = 16 + 40 * vectors.size();
    repeat (16) @(posedge bitinclk);
    foreach (vectors[p]) begin
      run_packet(vectors[p]);
    end
    if (vectors.size() == 0) begin
      error_count++;
      $display("no packets were read from the stimulus file");
    end
    error_count += u_dut.u_props.failures;
    $display("packets %0d, checks %0d, assertion failures %0d, errors %0d", vectors.size(),
             check_count, u_dut.u_props.failures, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // run limit scales with the number of packets
  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge bitinclk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the packets did not finish", cycle_count);
    $display("Simulation failed");
    $finish;
  end

endmodule
